// File: compile.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/issue_ctrl.sv
rtl/scoreboard_table.sv
rtl/operand_dispatch.sv
rtl/writeback_arbiter.sv
rtl/ctrl_unit.sv
testbench/ctrl_checker.sv
testbench/tb_ctrl_unit.sv

// File: run_sim.sh
#!/bin/bash
# build and run the ctrl_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_ctrl_unit -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// File: testbench/tb_ctrl_unit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module tb_ctrl_unit;
    localparam int NUM_ROWS = 32;

    logic        clk, rst, alu_done, mem_done, jump_done, is_jump;
    logic [31:0] pc, inst, imm;
    logic        is_en, alu_en, mem_en, jump_en, alu_use_pc, alu_use_imm, mem_we, reg_write;
    logic [2:0]  imm_sel, mem_bhw, write_sel;
    logic [31:0] pc_ctrl, imm_ctrl;
    logic [4:0]  rs1_ctrl, rs2_ctrl, jump_op, rd_ctrl;
    logic [3:0]  alu_op;

    // table columns
    logic [31:0] t_inst [NUM_ROWS];
    logic [2:0]  t_done [NUM_ROWS];    // jump, mem, alu
    logic        t_isj [NUM_ROWS];
    logic [1:0]  t_iss [NUM_ROWS];     // unit expected to issue
    logic        t_is_en [NUM_ROWS];
    logic [2:0]  t_en [NUM_ROWS];
    logic        t_rw [NUM_ROWS];
    logic [4:0]  t_rd [NUM_ROWS];
    logic [2:0]  t_wsel [NUM_ROWS];
    logic [2:0]  t_isel [NUM_ROWS];
    logic [4:0]  t_op [NUM_ROWS];
    logic [4:0]  t_rs1 [NUM_ROWS];
    logic [4:0]  t_rs2 [NUM_ROWS];
    logic        t_use_pc [NUM_ROWS];
    int          n_rows;

    logic [31:0] unit_pc [4];
    logic [31:0] unit_imm [4];
    logic        check_en, exp_is_en, exp_rw, exp_use_pc;
    logic [2:0]  exp_en, exp_wsel, exp_isel;
    logic [4:0]  exp_rd, exp_op, exp_rs1, exp_rs2;
    logic [31:0] exp_pc, exp_imm;
    int          row, err_cnt, check_cnt;

    ctrl_unit u_ctrl_unit (
        .clk(clk), .rst(rst), .pc(pc), .inst(inst), .imm(imm),
        .alu_done(alu_done), .mem_done(mem_done), .jump_done(jump_done), .is_jump(is_jump),
        .is_en(is_en), .imm_sel(imm_sel), .alu_en(alu_en), .mem_en(mem_en), .jump_en(jump_en),
        .pc_ctrl(pc_ctrl), .imm_ctrl(imm_ctrl), .rs1_ctrl(rs1_ctrl), .rs2_ctrl(rs2_ctrl),
        .jump_op(jump_op), .alu_op(alu_op), .alu_use_pc(alu_use_pc), .alu_use_imm(alu_use_imm),
        .mem_we(mem_we), .mem_bhw(mem_bhw), .write_sel(write_sel), .reg_write(reg_write),
        .rd_ctrl(rd_ctrl)
    );

    ctrl_checker u_checker (
        .clk(clk), .check_en(check_en), .row(row), .exp_is_en(exp_is_en), .exp_en(exp_en),
        .exp_rw(exp_rw), .exp_rd(exp_rd), .exp_wsel(exp_wsel), .exp_isel(exp_isel),
        .exp_op(exp_op), .exp_rs1(exp_rs1), .exp_rs2(exp_rs2), .exp_use_pc(exp_use_pc),
        .exp_pc(exp_pc), .exp_imm(exp_imm),
        .is_en(is_en), .imm_sel(imm_sel), .alu_en(alu_en), .mem_en(mem_en), .jump_en(jump_en),
        .pc_ctrl(pc_ctrl), .imm_ctrl(imm_ctrl), .rs1_ctrl(rs1_ctrl), .rs2_ctrl(rs2_ctrl),
        .jump_op(jump_op), .alu_op(alu_op), .alu_use_pc(alu_use_pc), .alu_use_imm(alu_use_imm),
        .mem_we(mem_we), .mem_bhw(mem_bhw),
        .write_sel(write_sel), .reg_write(reg_write), .rd_ctrl(rd_ctrl),
        .err_cnt(err_cnt), .check_cnt(check_cnt)
    );

    always #10 clk = ~clk;

    task automatic add_row(input logic [31:0] i, input logic [2:0] d, input logic j,
                           input logic [1:0] iss, input logic ie, input logic [2:0] en,
                           input logic rw, input logic [4:0] rd, input logic [2:0] ws,
                           input logic [2:0] isel, input logic [4:0] op, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic use_pc);
        t_inst[n_rows] = i;
        t_done[n_rows] = d;
        t_isj[n_rows]  = j;
        t_iss[n_rows]  = iss;
        t_is_en[n_rows] = ie;
        t_en[n_rows]   = en;
        t_rw[n_rows]   = rw;
        t_rd[n_rows]   = rd;
        t_wsel[n_rows] = ws;
        t_isel[n_rows] = isel;
        t_op[n_rows]   = op;
        t_rs1[n_rows]  = rs1;
        t_rs2[n_rows]  = rs2;
        t_use_pc[n_rows] = use_pc;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        // structural and waw stall, addi x1 then lw x1
        add_row(32'h00510093, 3'b000, 0, `FU_ALU,  1, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        add_row(32'h407302b3, 3'b000, 0, `FU_NONE, 0, 3'b001, 0, 0,  0, 0, 5'h11, 2, 0, 0);
        add_row(32'h00042083, 3'b001, 0, `FU_NONE, 0, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        add_row(32'h00042083, 3'b000, 0, `FU_NONE, 0, 3'b000, 1, 1,  0, 1, 0, 0, 0, 0);
        add_row(32'h00042083, 3'b000, 0, `FU_MEM,  1, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        // raw through x10
        add_row(32'h00310533, 3'b010, 0, `FU_ALU,  1, 3'b010, 0, 0,  0, 0, 5'h04, 8, 0, 0);
        add_row(32'h00051603, 3'b000, 0, `FU_NONE, 0, 3'b001, 1, 1,  1, 1, 5'h01, 2, 3, 0);
        add_row(32'h00051603, 3'b001, 0, `FU_MEM,  1, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 10, 0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b010, 0, 0,  0, 0, 5'h02, 10, 0, 0);
        add_row(32'h00000000, 3'b010, 0, `FU_NONE, 1, 3'b000, 0, 0,  0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 12, 1, 0, 0, 0, 0, 0);
        // store reads x14 before jal writes it
        add_row(32'h00310a33, 3'b000, 0, `FU_ALU,  1, 3'b000, 0, 0,  0, 0, 0, 0, 0, 0);
        add_row(32'h01472023, 3'b000, 0, `FU_MEM,  1, 3'b001, 0, 0,  0, 2, 5'h01, 2, 3, 0);
        add_row(32'h0000076f, 3'b000, 0, `FU_JUMP, 1, 3'b000, 0, 0,  0, 5, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b100, 0, `FU_NONE, 0, 3'b100, 0, 0,  0, 0, 5'h10, 0, 0, 0);
        add_row(32'h00000000, 3'b001, 0, `FU_NONE, 1, 3'b000, 0, 0,  0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 20, 0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b010, 0, 0,  0, 0, 5'h05, 14, 20, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 14, 4, 0, 0, 0, 0, 0);
        // taken branch and flush
        add_row(32'h00001063, 3'b010, 0, `FU_JUMP, 1, 3'b000, 0, 0,  0, 3, 0, 0, 0, 0);
        add_row(32'h00510093, 3'b000, 0, `FU_NONE, 0, 3'b100, 1, 0,  1, 1, 5'h01, 0, 0, 0);
        add_row(32'h00510093, 3'b100, 1, `FU_NONE, 0, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        add_row(32'h00510093, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 0,  4, 1, 0, 0, 0, 0);
        add_row(32'h00510093, 3'b000, 0, `FU_ALU,  1, 3'b000, 0, 0,  0, 1, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b001, 0, 0,  0, 0, 5'h11, 2, 0, 0);
        add_row(32'h00000000, 3'b001, 0, `FU_NONE, 1, 3'b000, 0, 0,  0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 1,  0, 0, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 0, 0,  0, 0, 0, 0, 0, 0);
        // auipc x3 goes out as add with pc
        add_row(32'h12345197, 3'b000, 0, `FU_ALU,  1, 3'b000, 0, 0,  0, 4, 0, 0, 0, 0);
        add_row(32'h00000000, 3'b001, 0, `FU_NONE, 1, 3'b001, 0, 0,  0, 0, 5'h11, 0, 0, 1);
        add_row(32'h00000000, 3'b000, 0, `FU_NONE, 1, 3'b000, 1, 3,  0, 0, 0, 0, 0, 0);
    endtask

    initial begin
        #((NUM_ROWS + 25) * 20);
        $display("ERROR: watchdog timeout, the row loop did not finish");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk = 0;
        rst = 1;
        {pc, inst, imm, alu_done, mem_done, jump_done, is_jump} = '0;
        {check_en, exp_is_en, exp_en, exp_rw, exp_rd, exp_wsel, exp_isel} = '0;
        {exp_op, exp_rs1, exp_pc, exp_imm} = '0;
        {exp_rs2, exp_use_pc} = '0;
        row = 0;
        void'($urandom(32'ha6610ccb));
        build_table();
        repeat (3) @(negedge clk);
        rst = 0;
        for (int r = 0; r < n_rows; r++) begin
            row  = r;
            inst = t_inst[r];
            pc   = $urandom;
            imm  = $urandom;
            {jump_done, mem_done, alu_done} = t_done[r];
            is_jump = t_isj[r];
            {exp_is_en, exp_en, exp_rw, exp_rd} = {t_is_en[r], t_en[r], t_rw[r], t_rd[r]};
            {exp_wsel, exp_isel, exp_op, exp_rs1} = {t_wsel[r], t_isel[r], t_op[r], t_rs1[r]};
            {exp_rs2, exp_use_pc} = {t_rs2[r], t_use_pc[r]};
            exp_pc  = t_en[r][2] ? unit_pc[`FU_JUMP] :
                      t_en[r][1] ? unit_pc[`FU_MEM]  : unit_pc[`FU_ALU];
            exp_imm = t_en[r][2] ? unit_imm[`FU_JUMP] :
                      t_en[r][1] ? unit_imm[`FU_MEM]  : unit_imm[`FU_ALU];
            if (t_iss[r] != `FU_NONE) begin
                unit_pc[t_iss[r]]  = pc;    // seen at dispatch of that unit
                unit_imm[t_iss[r]] = imm;
            end
            check_en = 1;
            @(negedge clk);
        end
        check_en = 0;
        $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: testbench/ctrl_checker.sv
`timescale 1ns/1ps

module ctrl_checker (
    input  logic        clk,
    input  logic        check_en,
    input  int          row,
    input  logic        exp_is_en,
    input  logic [2:0]  exp_en,     // jump, mem, alu
    input  logic        exp_rw,
    input  logic [4:0]  exp_rd,
    input  logic [2:0]  exp_wsel,
    input  logic [2:0]  exp_isel,
    input  logic [4:0]  exp_op,
    input  logic [4:0]  exp_rs1,
    input  logic [4:0]  exp_rs2,
    input  logic        exp_use_pc,
    input  logic [31:0] exp_pc,
    input  logic [31:0] exp_imm,
    input  logic        is_en,
    input  logic [2:0]  imm_sel,
    input  logic        alu_en,
    input  logic        mem_en,
    input  logic        jump_en,
    input  logic [31:0] pc_ctrl,
    input  logic [31:0] imm_ctrl,
    input  logic [4:0]  rs1_ctrl,
    input  logic [4:0]  rs2_ctrl,
    input  logic [4:0]  jump_op,
    input  logic [3:0]  alu_op,
    input  logic        alu_use_pc,
    input  logic        alu_use_imm,
    input  logic        mem_we,
    input  logic [2:0]  mem_bhw,
    input  logic [2:0]  write_sel,
    input  logic        reg_write,
    input  logic [4:0]  rd_ctrl,
    output int          err_cnt,
    output int          check_cnt
);
    logic [4:0] act_op;

    initial begin
        err_cnt   = 0;
        check_cnt = 0;
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %0t: row %0d %s expected %0h got %0h",
                     $time, row, what, exp, got);
        end
    endtask

    // op word as the active unit sees it
    assign act_op = alu_en ? {alu_use_imm, alu_op} :
                    mem_en ? {1'b0, mem_bhw, mem_we} : jump_op;

    always @(posedge clk) begin
        if (check_en) begin
            compare("is_en", exp_is_en, is_en);
            compare("imm_sel", exp_isel, imm_sel);
            compare("unit enables", exp_en, {jump_en, mem_en, alu_en});
            compare("reg_write", exp_rw, reg_write);
            compare("alu_use_pc", exp_use_pc, alu_use_pc);
            if (exp_rw) begin
                compare("rd_ctrl", exp_rd, rd_ctrl);
                compare("write_sel", exp_wsel, write_sel);
            end
            if (exp_en != 3'b000) begin
                compare("op", exp_op, act_op);
                compare("rs1_ctrl", exp_rs1, rs1_ctrl);
                compare("rs2_ctrl", exp_rs2, rs2_ctrl);
                compare("pc_ctrl", exp_pc, pc_ctrl);
                compare("imm_ctrl", exp_imm, imm_ctrl);
            end
        end
    end

endmodule

// File: rtl/ctrl_unit.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module ctrl_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic [31:0]        pc,
    input  logic [31:0]        inst,
    input  logic [31:0]        imm,
    input  logic               alu_done,
    input  logic               mem_done,
    input  logic               jump_done,
    input  logic               is_jump,
    output logic               is_en,
    output logic [2:0]         imm_sel,
    output logic               alu_en,
    output logic               mem_en,
    output logic               jump_en,
    output logic [31:0]        pc_ctrl,
    output logic [31:0]        imm_ctrl,
    output logic [`REG_AW-1:0] rs1_ctrl,
    output logic [`REG_AW-1:0] rs2_ctrl,
    output logic [4:0]         jump_op,
    output logic [3:0]         alu_op,
    output logic               alu_use_pc,
    output logic               alu_use_imm,
    output logic               mem_we,
    output logic [2:0]         mem_bhw,
    output logic [2:0]         write_sel,
    output logic               reg_write,
    output logic [`REG_AW-1:0] rd_ctrl
);
    import ctrl_pkg::*;

    fu_id_t             dec_fu;
    op_field_u          dec_op;
    logic [`REG_AW-1:0] dec_dst, dec_src1, dec_src2;
    logic               target_busy, dst_pending, ro_en;
    fu_entry_t          entries [1:`FU_NUM];
    logic [31:0]        pc_regs [1:`FU_NUM];
    logic [31:0]        imm_regs [1:`FU_NUM];
    logic [`FU_NUM:1]   rd_grant, wb_grant;

    inst_decoder u_dec (
        .inst(inst), .fu(dec_fu), .op(dec_op), .dst(dec_dst),
        .src1(dec_src1), .src2(dec_src2), .imm_sel(imm_sel)
    );

    issue_ctrl u_issue (
        .clk(clk), .rst(rst), .fu(dec_fu),
        .target_busy(target_busy), .dst_pending(dst_pending),
        .jump_done(jump_done), .is_jump(is_jump),
        .is_en(is_en), .ro_en(ro_en)
    );

    scoreboard_table u_table (
        .clk(clk), .rst(rst), .ro_en(ro_en),
        .fu(dec_fu), .op(dec_op), .dst(dec_dst), .src1(dec_src1), .src2(dec_src2),
        .pc(pc), .imm(imm),
        .fu_done({jump_done, mem_done, alu_done}),   // indexed by unit code
        .rd_grant(rd_grant), .wb_grant(wb_grant),
        .entries(entries), .pc_regs(pc_regs), .imm_regs(imm_regs),
        .target_busy(target_busy), .dst_pending(dst_pending)
    );

    operand_dispatch u_dispatch (
        .entries(entries), .pc_regs(pc_regs), .imm_regs(imm_regs),
        .rd_grant(rd_grant),
        .alu_en(alu_en), .mem_en(mem_en), .jump_en(jump_en),
        .pc_ctrl(pc_ctrl), .imm_ctrl(imm_ctrl),
        .rs1_ctrl(rs1_ctrl), .rs2_ctrl(rs2_ctrl),
        .jump_op(jump_op), .alu_op(alu_op),
        .alu_use_pc(alu_use_pc), .alu_use_imm(alu_use_imm),
        .mem_we(mem_we), .mem_bhw(mem_bhw)
    );

    writeback_arbiter u_wb (
        .entries(entries), .wb_grant(wb_grant),
        .write_sel(write_sel), .reg_write(reg_write), .rd_ctrl(rd_ctrl)
    );

endmodule

// File: rtl/writeback_arbiter.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module writeback_arbiter (
    input  ctrl_pkg::fu_entry_t entries [1:`FU_NUM],
    output logic [`FU_NUM:1]    wb_grant,
    output logic [2:0]          write_sel,
    output logic                reg_write,
    output logic [`REG_AW-1:0]  rd_ctrl
);
    import ctrl_pkg::*;

    logic [`FU_NUM:1] war_ok;
    logic [`FU_NUM:1] eligible;
    fu_id_t           win;

    // war: nobody may still owe a read of the register being written
    always_comb begin
        for (int u = 1; u <= `FU_NUM; u++) begin
            war_ok[u] = 1'b1;
            for (int v = 1; v <= `FU_NUM; v++) begin
                if (v != u && entries[v].busy && entries[u].dst != '0) begin
                    if (entries[v].rdy1 && entries[v].src1 == entries[u].dst)
                        war_ok[u] = 1'b0;
                    if (entries[v].rdy2 && entries[v].src2 == entries[u].dst)
                        war_ok[u] = 1'b0;
                end
            end
            eligible[u] = entries[u].done & war_ok[u];
        end
    end

    assign win       = prio_pick(eligible);
    assign reg_write = win != `FU_NONE;

    always_comb begin
        for (int u = 1; u <= `FU_NUM; u++)
            wb_grant[u] = win == fu_id_t'(u);
        write_sel = `WB_ALU;
        rd_ctrl   = '0;
        case (win)
            `FU_ALU: rd_ctrl = entries[`FU_ALU].dst;
            `FU_MEM: begin
                write_sel = `WB_MEM;
                rd_ctrl   = entries[`FU_MEM].dst;
            end
            `FU_JUMP: begin
                write_sel = `WB_JUMP;   // link address
                rd_ctrl   = entries[`FU_JUMP].dst;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/operand_dispatch.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module operand_dispatch (
    input  ctrl_pkg::fu_entry_t entries [1:`FU_NUM],
    input  logic [31:0]         pc_regs [1:`FU_NUM],
    input  logic [31:0]         imm_regs [1:`FU_NUM],
    output logic [`FU_NUM:1]    rd_grant,
    output logic                alu_en,
    output logic                mem_en,
    output logic                jump_en,
    output logic [31:0]         pc_ctrl,
    output logic [31:0]         imm_ctrl,
    output logic [`REG_AW-1:0]  rs1_ctrl,
    output logic [`REG_AW-1:0]  rs2_ctrl,
    output logic [4:0]          jump_op,
    output logic [3:0]          alu_op,
    output logic                alu_use_pc,
    output logic                alu_use_imm,
    output logic                mem_we,
    output logic [2:0]          mem_bhw
);
    import ctrl_pkg::*;

    logic [`FU_NUM:1] ready;
    fu_id_t           sel;
    fu_entry_t        e;
    logic             is_auipc;

    always_comb begin
        for (int u = 1; u <= `FU_NUM; u++) begin
            ready[u]    = entries[u].rdy1 & entries[u].rdy2;
            rd_grant[u] = sel == fu_id_t'(u);
        end
    end

    assign sel = prio_pick(ready);

    always_comb begin
        e        = '0;
        pc_ctrl  = '0;
        imm_ctrl = '0;
        if (sel != `FU_NONE) begin
            e        = entries[sel];
            pc_ctrl  = pc_regs[sel];
            imm_ctrl = imm_regs[sel];
        end
    end

    assign alu_en   = sel == `FU_ALU;
    assign mem_en   = sel == `FU_MEM;
    assign jump_en  = sel == `FU_JUMP;
    assign rs1_ctrl = e.src1;
    assign rs2_ctrl = e.src2;   // store data for mem

    assign is_auipc    = alu_en && e.op.alu.alu_op == `ALU_AUIPC;
    assign alu_use_pc  = is_auipc;
    assign alu_use_imm = alu_en & e.op.alu.use_imm;
    assign alu_op      = !alu_en ? 4'd0 : is_auipc ? `ALU_ADD : e.op.alu.alu_op;
    assign mem_we      = mem_en & e.op.mem.we;
    assign mem_bhw     = mem_en ? e.op.mem.bhw : 3'd0;
    assign jump_op     = jump_en ? e.op.jump_op : 5'd0;

endmodule

// File: rtl/scoreboard_table.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module scoreboard_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                ro_en,
    input  ctrl_pkg::fu_id_t    fu,
    input  ctrl_pkg::op_field_u op,
    input  logic [`REG_AW-1:0]  dst,
    input  logic [`REG_AW-1:0]  src1,
    input  logic [`REG_AW-1:0]  src2,
    input  logic [31:0]         pc,
    input  logic [31:0]         imm,
    input  logic [`FU_NUM:1]    fu_done,
    input  logic [`FU_NUM:1]    rd_grant,
    input  logic [`FU_NUM:1]    wb_grant,
    output ctrl_pkg::fu_entry_t entries [1:`FU_NUM],
    output logic [31:0]         pc_regs [1:`FU_NUM],
    output logic [31:0]         imm_regs [1:`FU_NUM],
    output logic                target_busy,
    output logic                dst_pending
);
    import ctrl_pkg::*;

    fu_id_t rrs [0:(1 << `REG_AW)-1];   // pending writer per register
    fu_id_t wb_fu;
    fu_id_t src1_fu, src2_fu;
    logic   src1_rdy, src2_rdy;

    always_comb begin
        wb_fu = `FU_NONE;
        for (int u = 1; u <= `FU_NUM; u++) begin
            if (wb_grant[u])
                wb_fu = fu_id_t'(u);
        end
    end

    assign src1_fu  = rrs[src1];
    assign src2_fu  = rrs[src2];
    // a writer granted this cycle counts as done for the issuing entry
    assign src1_rdy = src1_fu == `FU_NONE || src1_fu == wb_fu;
    assign src2_rdy = src2_fu == `FU_NONE || src2_fu == wb_fu;

    assign target_busy = (fu != `FU_NONE) && entries[fu].busy;
    assign dst_pending = rrs[dst] != `FU_NONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = 1; u <= `FU_NUM; u++)
                entries[u] <= '0;
            for (int r = 0; r < (1 << `REG_AW); r++)
                rrs[r] <= `FU_NONE;
        end else begin
            for (int u = 1; u <= `FU_NUM; u++) begin
                if (wb_grant[u]) begin
                    entries[u] <= '0;
                    rrs[entries[u].dst] <= `FU_NONE;
                end else if (entries[u].busy) begin
                    if (fu_done[u])
                        entries[u].done <= 1'b1;   // held until granted
                    if (rd_grant[u]) begin
                        entries[u].rdy1 <= 1'b0;
                        entries[u].rdy2 <= 1'b0;
                    end
                    // raw wake-up
                    if (wb_fu != `FU_NONE && entries[u].fu1 == wb_fu) begin
                        entries[u].rdy1 <= 1'b1;
                        entries[u].fu1  <= `FU_NONE;
                    end
                    if (wb_fu != `FU_NONE && entries[u].fu2 == wb_fu) begin
                        entries[u].rdy2 <= 1'b1;
                        entries[u].fu2  <= `FU_NONE;
                    end
                end
            end
            if (ro_en) begin
                entries[fu] <= '{busy: 1'b1, op: op, dst: dst, src1: src1, src2: src2,
                                 fu1: src1_rdy ? `FU_NONE : src1_fu,
                                 fu2: src2_rdy ? `FU_NONE : src2_fu,
                                 rdy1: src1_rdy, rdy2: src2_rdy, done: 1'b0};
                if (dst != '0)
                    rrs[dst] <= fu;   // x0 never pending
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ro_en) begin
            pc_regs[fu]  <= pc;
            imm_regs[fu] <= imm;
        end
    end

endmodule

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module issue_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  ctrl_pkg::fu_id_t fu,
    input  logic             target_busy,
    input  logic             dst_pending,
    input  logic             jump_done,
    input  logic             is_jump,
    output logic             is_en,
    output logic             ro_en
);
    logic ctrl_stall;
    logic flush;
    logic hazard;

    assign hazard = target_busy | dst_pending;   // structural or waw

    // flush lets fetch move past the wrong-path word
    assign is_en = flush | (~hazard & ~ctrl_stall);
    assign ro_en = ~flush & ~hazard & ~ctrl_stall & (fu != `FU_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_stall <= 1'b0;
        end else if (ro_en && fu == `FU_JUMP) begin
            ctrl_stall <= 1'b1;   // hold issue until the target is known
        end else if (jump_done) begin
            ctrl_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= jump_done & is_jump;
        end
    end

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps
`include "ctrl_macros.svh"

module inst_decoder (
    input  logic [31:0]         inst,
    output ctrl_pkg::fu_id_t    fu,
    output ctrl_pkg::op_field_u op,
    output logic [`REG_AW-1:0]  dst,
    output logic [`REG_AW-1:0]  src1,
    output logic [`REG_AW-1:0]  src2,
    output logic [2:0]          imm_sel
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero, f7_alt, r_ok, i_ok;
    logic       use_rd, use_rs1, use_rs2;

    function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    alu_code = alt ? `ALU_SUB : `ALU_ADD;
            3'd1:    alu_code = `ALU_SLL;
            3'd2:    alu_code = `ALU_SLT;
            3'd3:    alu_code = `ALU_SLTU;
            3'd4:    alu_code = `ALU_XOR;
            3'd5:    alu_code = alt ? `ALU_SRA : `ALU_SRL;
            3'd6:    alu_code = `ALU_OR;
            default: alu_code = `ALU_AND;
        endcase
    endfunction

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = funct7 == 7'h00;
    assign f7_alt  = funct7 == 7'h20;
    assign r_ok    = f7_zero | (f7_alt & (funct3 == 3'd0 | funct3 == 3'd5));
    // only shifts care about funct7
    assign i_ok    = (funct3 == 3'd1) ? f7_zero :
                     (funct3 == 3'd5) ? (f7_zero | f7_alt) : 1'b1;

    always_comb begin
        fu      = `FU_NONE;
        op      = '0;
        imm_sel = 3'd0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            7'b0110011: if (r_ok) begin
                fu = `FU_ALU;
                op.alu.alu_op = alu_code(funct3, f7_alt);
                {use_rd, use_rs1, use_rs2} = 3'b111;
            end
            7'b0010011: if (i_ok) begin
                fu = `FU_ALU;
                op.alu.use_imm = 1'b1;
                op.alu.alu_op = alu_code(funct3, f7_alt & (funct3 == 3'd5));
                {use_rd, use_rs1} = 2'b11;
                imm_sel = `IMM_I;
            end
            7'b0000011: if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                fu = `FU_MEM;
                op.mem.bhw = funct3;
                {use_rd, use_rs1} = 2'b11;
                imm_sel = `IMM_I;
            end
            7'b0100011: if (funct3 < 3'd3) begin
                fu = `FU_MEM;
                op.mem.bhw = funct3;
                op.mem.we = 1'b1;
                {use_rs1, use_rs2} = 2'b11;
                imm_sel = `IMM_S;
            end
            7'b1100011: if (funct3 != 3'd2 && funct3 != 3'd3) begin
                fu = `FU_JUMP;
                op.jump_op = {2'b00, funct3};
                {use_rs1, use_rs2} = 2'b11;
                imm_sel = `IMM_B;
            end
            7'b1101111: begin
                fu = `FU_JUMP;
                op.jump_op = `JUMP_JAL;
                use_rd = 1'b1;
                imm_sel = `IMM_J;
            end
            7'b1100111: if (funct3 == 3'd0) begin
                fu = `FU_JUMP;
                op.jump_op = `JUMP_JALR;
                {use_rd, use_rs1} = 2'b11;
                imm_sel = `IMM_I;
            end
            7'b0110111, 7'b0010111: begin   // lui, auipc
                fu = `FU_ALU;
                op.alu.use_imm = 1'b1;
                op.alu.alu_op = opcode[5] ? `ALU_LUI : `ALU_AUIPC;
                use_rd = 1'b1;
                imm_sel = `IMM_U;
            end
            default: ;
        endcase
    end

    assign dst  = use_rd  ? inst[11:7]  : '0;
    assign src1 = use_rs1 ? inst[19:15] : '0;
    assign src2 = use_rs2 ? inst[24:20] : '0;

endmodule

// File: rtl/ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

    typedef logic [1:0] fu_id_t;

    typedef struct packed {
        logic       use_imm;
        logic [3:0] alu_op;
    } alu_view_t;

    typedef struct packed {
        logic       spare;
        logic [2:0] bhw;    // funct3 of the load or store
        logic       we;
    } mem_view_t;

    // one op word, read per unit
    typedef union packed {
        alu_view_t  alu;
        mem_view_t  mem;
        logic [4:0] jump_op;
    } op_field_u;

    typedef struct packed {
        logic              busy;
        op_field_u         op;
        logic [`REG_AW-1:0] dst;
        logic [`REG_AW-1:0] src1;
        logic [`REG_AW-1:0] src2;
        fu_id_t            fu1;
        fu_id_t            fu2;
        logic              rdy1;
        logic              rdy2;
        logic              done;
    } fu_entry_t;

    // fixed priority: jump, alu, mem
    function automatic fu_id_t prio_pick(input logic [`FU_NUM:1] req);
        if (req[`FU_JUMP])
            return `FU_JUMP;
        if (req[`FU_ALU])
            return `FU_ALU;
        if (req[`FU_MEM])
            return `FU_MEM;
        return `FU_NONE;
    endfunction

endpackage

// File: rtl/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

`define REG_AW      5
`define FU_NUM      3

// unit codes, 0 marks no pending writer
`define FU_NONE     2'd0
`define FU_ALU      2'd1
`define FU_MEM      2'd2
`define FU_JUMP     2'd3

`define IMM_I       3'd1
`define IMM_S       3'd2
`define IMM_B       3'd3
`define IMM_U       3'd4
`define IMM_J       3'd5

`define WB_ALU      3'd0
`define WB_MEM      3'd1
`define WB_JUMP     3'd4

`define ALU_ADD     4'd1
`define ALU_SUB     4'd2
`define ALU_AND     4'd3
`define ALU_OR      4'd4
`define ALU_XOR     4'd5
`define ALU_SLL     4'd6
`define ALU_SRL     4'd7
`define ALU_SRA     4'd8
`define ALU_SLT     4'd9
`define ALU_SLTU    4'd10
`define ALU_LUI     4'd11
`define ALU_AUIPC   4'd12   // turned into add with pc at dispatch

// branches use {2'b00, funct3}
`define JUMP_JAL    5'h10
`define JUMP_JALR   5'h11

`endif
